//--- common/mem_cfg_pkg.sv
// Local memory configuration constants
// Default bank count and Avalon-MM widths for the memory banks,
// plus the depth of the read-data return pipeline

package mem_cfg_pkg;

   // ========================================
   // Bank organisation
   // ========================================

   // Number of local memory banks behind the shell
   localparam int unsigned NUM_BANKS = 4;

   // ========================================
   // Avalon-MM widths
   // ========================================

   // Word address, reduced for simulation
   localparam int unsigned ADDR_WIDTH       = 16;
   localparam int unsigned DATA_WIDTH       = 64;
   // Bits covered by one byteenable bit
   localparam int unsigned SYMBOL_WIDTH     = 8;
   localparam int unsigned BURSTCOUNT_WIDTH = 7;

   // Register stages on the read-data return path
   localparam int unsigned READDATA_PIPE_DEPTH = 2;

endpackage

//--- common/reset_cfg_pkg.sv
// Bank reset generation constants
// Synchronizer length, extra register stages and the resulting latency

package reset_cfg_pkg;

   // Flops in the release synchronizer
   localparam int unsigned SYNC_CHAIN_LENGTH = 2;

   // Register stages after the synchronizer, for fan-out timing
   localparam int unsigned RESET_EXTRA_STAGES = 1;

   // Clock edges from rst_n release to bank reset release
   localparam int unsigned RESET_LATENCY = SYNC_CHAIN_LENGTH + RESET_EXTRA_STAGES;

endpackage

//--- hdl/reset_resync.sv
// Reset release synchronizer
// Asserts asynchronously on rst_n and releases after LENGTH clock edges

`timescale 1ns/1ns

module reset_resync
#(
   parameter int LENGTH = reset_cfg_pkg::SYNC_CHAIN_LENGTH
)
(
   input  logic Clk_100,
   input  logic rst_n,
   output logic reset_sync
);

   logic [LENGTH-1:0] sync_chain;

   // Chain presets to one and shifts in zero once rst_n is released
   always_ff @(posedge Clk_100 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         sync_chain <= '1;
      end
      else
      begin
         sync_chain[0] <= 1'b0;
         for (int i = 1; i < LENGTH; i++)
         begin
            sync_chain[i] <= sync_chain[i-1];
         end
      end
   end

   assign reset_sync = sync_chain[LENGTH-1];

   // A low rst_n keeps the synchronized reset active through the next edge
   a_reset_held: assert property (@(posedge Clk_100) !rst_n |=> reset_sync);

endmodule

//--- local_mem/avmm_pipe_bridge.sv
// Avalon-MM pipeline bridge between the user side (s0) and memory side (m0)
// Registered command stage, one command deep under back-pressure
// Fixed depth read-data return pipeline

`timescale 1ns/1ns

module avmm_pipe_bridge
#(
   parameter int DATA_WIDTH          = 64,
   parameter int ADDR_WIDTH          = 16,
   parameter int BURSTCOUNT_WIDTH    = 7,
   parameter int READDATA_PIPE_DEPTH = 2,
   localparam int BE_WIDTH           = DATA_WIDTH / mem_cfg_pkg::SYMBOL_WIDTH
)
(
   input  logic                        Clk_100,
   // Active-high bank reset
   input  logic                        reset,

   // User side
   output logic                        s0_waitrequest,
   output logic [DATA_WIDTH-1:0]       s0_readdata,
   output logic                        s0_readdatavalid,
   input  logic [BURSTCOUNT_WIDTH-1:0] s0_burstcount,
   input  logic [DATA_WIDTH-1:0]       s0_writedata,
   input  logic [ADDR_WIDTH-1:0]       s0_address,
   input  logic                        s0_write,
   input  logic                        s0_read,
   input  logic [BE_WIDTH-1:0]         s0_byteenable,

   // Memory controller side
   input  logic                        m0_waitrequest,
   input  logic [DATA_WIDTH-1:0]       m0_readdata,
   input  logic                        m0_readdatavalid,
   output logic [BURSTCOUNT_WIDTH-1:0] m0_burstcount,
   output logic [DATA_WIDTH-1:0]       m0_writedata,
   output logic [ADDR_WIDTH-1:0]       m0_address,
   output logic                        m0_write,
   output logic                        m0_read,
   output logic [BE_WIDTH-1:0]         m0_byteenable
);

   // ========================================
   // Command stage
   // ========================================

   logic                        cmd_read;
   logic                        cmd_write;
   logic [ADDR_WIDTH-1:0]       cmd_address;
   logic [DATA_WIDTH-1:0]       cmd_writedata;
   logic [BURSTCOUNT_WIDTH-1:0] cmd_burstcount;
   logic [BE_WIDTH-1:0]         cmd_byteenable;

   // Stall only when a command is held and memory is not taking it
   assign s0_waitrequest = (cmd_read | cmd_write) & m0_waitrequest;

   always_ff @(posedge Clk_100 or posedge reset)
   begin
      if (reset)
      begin
         cmd_read  <= 1'b0;
         cmd_write <= 1'b0;
      end
      else if (!s0_waitrequest)
      begin
         cmd_read  <= s0_read;
         cmd_write <= s0_write;
      end
   end

   // Payload follows the same load enable
   always_ff @(posedge Clk_100)
   begin
      if (!s0_waitrequest)
      begin
         cmd_address    <= s0_address;
         cmd_writedata  <= s0_writedata;
         cmd_burstcount <= s0_burstcount;
         cmd_byteenable <= s0_byteenable;
      end
   end

   assign m0_read       = cmd_read;
   assign m0_write      = cmd_write;
   assign m0_address    = cmd_address;
   assign m0_writedata  = cmd_writedata;
   assign m0_burstcount = cmd_burstcount;
   assign m0_byteenable = cmd_byteenable;

   // ========================================
   // Read-data return pipe
   // ========================================

   logic [READDATA_PIPE_DEPTH-1:0] rdv_pipe;
   logic [DATA_WIDTH-1:0]          rdata_pipe [READDATA_PIPE_DEPTH];

   always_ff @(posedge Clk_100 or posedge reset)
   begin
      if (reset)
      begin
         rdv_pipe <= '0;
      end
      else
      begin
         rdv_pipe[0] <= m0_readdatavalid;
         for (int i = 1; i < READDATA_PIPE_DEPTH; i++)
         begin
            rdv_pipe[i] <= rdv_pipe[i-1];
         end
      end
   end

   always_ff @(posedge Clk_100)
   begin
      rdata_pipe[0] <= m0_readdata;
      for (int i = 1; i < READDATA_PIPE_DEPTH; i++)
      begin
         rdata_pipe[i] <= rdata_pipe[i-1];
      end
   end

   assign s0_readdatavalid = rdv_pipe[READDATA_PIPE_DEPTH-1];
   assign s0_readdata      = rdata_pipe[READDATA_PIPE_DEPTH-1];

   // User side must never issue read and write in one command
   a_no_rd_wr: assert property (@(posedge Clk_100) disable iff (reset)
      !(m0_read && m0_write));

   // Held command stays put until memory accepts it
   a_cmd_stable: assert property (@(posedge Clk_100) disable iff (reset)
      (m0_read || m0_write) && m0_waitrequest |=>
         $stable({m0_read, m0_write, m0_address, m0_writedata,
                  m0_burstcount, m0_byteenable}));

endmodule

//--- local_mem/local_mem_bank.sv
// One local memory bank path
// Bank reset generation and the Avalon-MM pipeline bridge

`timescale 1ns/1ns

module local_mem_bank
#(
   parameter int DATA_WIDTH          = 64,
   parameter int ADDR_WIDTH          = 16,
   parameter int BURSTCOUNT_WIDTH    = 7,
   parameter int READDATA_PIPE_DEPTH = 2,
   localparam int BE_WIDTH           = DATA_WIDTH / mem_cfg_pkg::SYMBOL_WIDTH
)
(
   input  logic                        Clk_100,
   input  logic                        rst_n,
   output logic                        bank_reset,

   output logic                        s0_waitrequest,
   output logic [DATA_WIDTH-1:0]       s0_readdata,
   output logic                        s0_readdatavalid,
   input  logic [BURSTCOUNT_WIDTH-1:0] s0_burstcount,
   input  logic [DATA_WIDTH-1:0]       s0_writedata,
   input  logic [ADDR_WIDTH-1:0]       s0_address,
   input  logic                        s0_write,
   input  logic                        s0_read,
   input  logic [BE_WIDTH-1:0]         s0_byteenable,

   input  logic                        m0_waitrequest,
   input  logic [DATA_WIDTH-1:0]       m0_readdata,
   input  logic                        m0_readdatavalid,
   output logic [BURSTCOUNT_WIDTH-1:0] m0_burstcount,
   output logic [DATA_WIDTH-1:0]       m0_writedata,
   output logic [ADDR_WIDTH-1:0]       m0_address,
   output logic                        m0_write,
   output logic                        m0_read,
   output logic [BE_WIDTH-1:0]         m0_byteenable
);

   localparam int EXTRA = reset_cfg_pkg::RESET_EXTRA_STAGES;

   logic             reset_sync;
   logic [EXTRA-1:0] reset_stage;

   reset_resync
   #(
      .LENGTH (reset_cfg_pkg::SYNC_CHAIN_LENGTH)
   )
   reset_resync_i
   (
      .Clk_100    (Clk_100),
      .rst_n      (rst_n),
      .reset_sync (reset_sync)
   );

   // Extra stages still assert with rst_n so the bank reset is never late to assert
   always_ff @(posedge Clk_100 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         reset_stage <= '1;
      end
      else
      begin
         reset_stage[0] <= reset_sync;
         for (int i = 1; i < EXTRA; i++)
         begin
            reset_stage[i] <= reset_stage[i-1];
         end
      end
   end

   assign bank_reset = reset_stage[EXTRA-1];

   avmm_pipe_bridge
   #(
      .DATA_WIDTH          (DATA_WIDTH),
      .ADDR_WIDTH          (ADDR_WIDTH),
      .BURSTCOUNT_WIDTH    (BURSTCOUNT_WIDTH),
      .READDATA_PIPE_DEPTH (READDATA_PIPE_DEPTH)
   )
   bridge_i
   (
      .Clk_100          (Clk_100),
      .reset            (bank_reset),
      .s0_waitrequest   (s0_waitrequest),
      .s0_readdata      (s0_readdata),
      .s0_readdatavalid (s0_readdatavalid),
      .s0_burstcount    (s0_burstcount),
      .s0_writedata     (s0_writedata),
      .s0_address       (s0_address),
      .s0_write         (s0_write),
      .s0_read          (s0_read),
      .s0_byteenable    (s0_byteenable),
      .m0_waitrequest   (m0_waitrequest),
      .m0_readdata      (m0_readdata),
      .m0_readdatavalid (m0_readdatavalid),
      .m0_burstcount    (m0_burstcount),
      .m0_writedata     (m0_writedata),
      .m0_address       (m0_address),
      .m0_write         (m0_write),
      .m0_read          (m0_read),
      .m0_byteenable    (m0_byteenable)
   );

endmodule

//--- hdl/green_shell_top.sv
// Local memory shell top level
// One bank path per memory bank, all on Clk_100

`timescale 1ns/1ns

module green_shell_top
#(
   parameter int NUM_BANKS           = mem_cfg_pkg::NUM_BANKS,
   parameter int DATA_WIDTH          = mem_cfg_pkg::DATA_WIDTH,
   parameter int ADDR_WIDTH          = mem_cfg_pkg::ADDR_WIDTH,
   parameter int BURSTCOUNT_WIDTH    = mem_cfg_pkg::BURSTCOUNT_WIDTH,
   parameter int READDATA_PIPE_DEPTH = mem_cfg_pkg::READDATA_PIPE_DEPTH,
   localparam int BE_WIDTH           = DATA_WIDTH / mem_cfg_pkg::SYMBOL_WIDTH
)
(
   input  logic                                       Clk_100,
   input  logic                                       rst_n,
   output logic [NUM_BANKS-1:0]                       bank_reset,

   // User side, indexed by bank
   output logic [NUM_BANKS-1:0]                       s0_waitrequest,
   output logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]       s0_readdata,
   output logic [NUM_BANKS-1:0]                       s0_readdatavalid,
   input  logic [NUM_BANKS-1:0][BURSTCOUNT_WIDTH-1:0] s0_burstcount,
   input  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]       s0_writedata,
   input  logic [NUM_BANKS-1:0][ADDR_WIDTH-1:0]       s0_address,
   input  logic [NUM_BANKS-1:0]                       s0_write,
   input  logic [NUM_BANKS-1:0]                       s0_read,
   input  logic [NUM_BANKS-1:0][BE_WIDTH-1:0]         s0_byteenable,

   // Memory controller side, indexed by bank
   input  logic [NUM_BANKS-1:0]                       m0_waitrequest,
   input  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]       m0_readdata,
   input  logic [NUM_BANKS-1:0]                       m0_readdatavalid,
   output logic [NUM_BANKS-1:0][BURSTCOUNT_WIDTH-1:0] m0_burstcount,
   output logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]       m0_writedata,
   output logic [NUM_BANKS-1:0][ADDR_WIDTH-1:0]       m0_address,
   output logic [NUM_BANKS-1:0]                       m0_write,
   output logic [NUM_BANKS-1:0]                       m0_read,
   output logic [NUM_BANKS-1:0][BE_WIDTH-1:0]         m0_byteenable
);

   // ========================================
   // Bank paths
   // ========================================

   for (genvar b = 0; b < NUM_BANKS; b++)
   begin : g_bank
      local_mem_bank
      #(
         .DATA_WIDTH          (DATA_WIDTH),
         .ADDR_WIDTH          (ADDR_WIDTH),
         .BURSTCOUNT_WIDTH    (BURSTCOUNT_WIDTH),
         .READDATA_PIPE_DEPTH (READDATA_PIPE_DEPTH)
      )
      bank_i
      (
         .Clk_100          (Clk_100),
         .rst_n            (rst_n),
         .bank_reset       (bank_reset[b]),
         .s0_waitrequest   (s0_waitrequest[b]),
         .s0_readdata      (s0_readdata[b]),
         .s0_readdatavalid (s0_readdatavalid[b]),
         .s0_burstcount    (s0_burstcount[b]),
         .s0_writedata     (s0_writedata[b]),
         .s0_address       (s0_address[b]),
         .s0_write         (s0_write[b]),
         .s0_read          (s0_read[b]),
         .s0_byteenable    (s0_byteenable[b]),
         .m0_waitrequest   (m0_waitrequest[b]),
         .m0_readdata      (m0_readdata[b]),
         .m0_readdatavalid (m0_readdatavalid[b]),
         .m0_burstcount    (m0_burstcount[b]),
         .m0_writedata     (m0_writedata[b]),
         .m0_address       (m0_address[b]),
         .m0_write         (m0_write[b]),
         .m0_read          (m0_read[b]),
         .m0_byteenable    (m0_byteenable[b])
      );
   end

endmodule

//--- testbench/tb_green_shell.sv
// Testbench for the local memory shell
// Clock, reset, per-bank memory model, LFSR data source,
// check task and the directed tests

`timescale 1ns/1ns

module tb_green_shell;

   localparam int NB    = 2;
   localparam int DW    = mem_cfg_pkg::DATA_WIDTH;
   localparam int AW    = mem_cfg_pkg::ADDR_WIDTH;
   localparam int BW    = mem_cfg_pkg::BURSTCOUNT_WIDTH;
   localparam int BEW   = DW / mem_cfg_pkg::SYMBOL_WIDTH;
   localparam int DEPTH = mem_cfg_pkg::READDATA_PIPE_DEPTH;
   localparam int TO    = 50;

   logic                       Clk_100 = 1'b0;
   logic                       rst_n = 1'b0;
   logic [NB-1:0]              bank_reset;
   logic [NB-1:0]              s0_waitrequest;
   logic [NB-1:0][DW-1:0]      s0_readdata;
   logic [NB-1:0]              s0_readdatavalid;
   logic [NB-1:0][BW-1:0]      s0_burstcount = '0;
   logic [NB-1:0][DW-1:0]      s0_writedata = '0;
   logic [NB-1:0][AW-1:0]      s0_address = '0;
   logic [NB-1:0]              s0_write = '0;
   logic [NB-1:0]              s0_read = '0;
   logic [NB-1:0][BEW-1:0]     s0_byteenable = '0;
   logic [NB-1:0]              m0_waitrequest = '0;
   logic [NB-1:0][DW-1:0]      m0_readdata = '0;
   logic [NB-1:0]              m0_readdatavalid = '0;
   logic [NB-1:0][BW-1:0]      m0_burstcount;
   logic [NB-1:0][DW-1:0]      m0_writedata;
   logic [NB-1:0][AW-1:0]      m0_address;
   logic [NB-1:0]              m0_write;
   logic [NB-1:0]              m0_read;
   logic [NB-1:0][BEW-1:0]     m0_byteenable;

   logic [DW-1:0] mem [NB][16];
   logic [AW-1:0] wr_addr_q [$];
   logic [DW-1:0] wr_data_q [$];
   logic [DW-1:0] rd_data_q [$];
   logic [31:0]   lfsr_state = 32'h38047eb2;
   int            errors = 0;
   int            timeouts = 0;

   green_shell_top
   #(
      .NUM_BANKS           (NB),
      .DATA_WIDTH          (DW),
      .ADDR_WIDTH          (AW),
      .BURSTCOUNT_WIDTH    (BW),
      .READDATA_PIPE_DEPTH (DEPTH)
   )
   dut_i
   (
      .Clk_100          (Clk_100),
      .rst_n            (rst_n),
      .bank_reset       (bank_reset),
      .s0_waitrequest   (s0_waitrequest),
      .s0_readdata      (s0_readdata),
      .s0_readdatavalid (s0_readdatavalid),
      .s0_burstcount    (s0_burstcount),
      .s0_writedata     (s0_writedata),
      .s0_address       (s0_address),
      .s0_write         (s0_write),
      .s0_read          (s0_read),
      .s0_byteenable    (s0_byteenable),
      .m0_waitrequest   (m0_waitrequest),
      .m0_readdata      (m0_readdata),
      .m0_readdatavalid (m0_readdatavalid),
      .m0_burstcount    (m0_burstcount),
      .m0_writedata     (m0_writedata),
      .m0_address       (m0_address),
      .m0_write         (m0_write),
      .m0_read          (m0_read),
      .m0_byteenable    (m0_byteenable)
   );

   initial
   begin
      forever
      begin
         #20 Clk_100 = ~Clk_100;
      end
   end

   // ========================================
   // Memory model with one cycle read latency
   // ========================================

   always @(posedge Clk_100)
   begin
      for (int b = 0; b < NB; b++)
      begin
         if (!rst_n)
         begin
            // Fill pattern covers bank and full word address
            for (int a = 0; a < 16; a++)
            begin
               mem[b][a] <= {32'hC0DE0000, 24'h0, 4'(b), 4'(a)};
            end
            // Valid stays high in reset so the bridge has to block it
            m0_readdatavalid[b] <= 1'b1;
         end
         else
         begin
            m0_readdatavalid[b] <= 1'b0;
            if (m0_write[b] && !m0_waitrequest[b])
            begin
               mem[b][m0_address[b][3:0]] <= m0_writedata[b];
               if (b == 0)
               begin
                  wr_addr_q.push_back(m0_address[b]);
                  wr_data_q.push_back(m0_writedata[b]);
               end
            end
            if (m0_read[b] && !m0_waitrequest[b])
            begin
               m0_readdatavalid[b] <= 1'b1;
               m0_readdata[b]      <= mem[b][m0_address[b][3:0]];
            end
         end
      end
   end

   // Read data returned to the user side of bank 0
   always @(posedge Clk_100)
   begin
      if (s0_readdatavalid[0])
      begin
         rd_data_q.push_back(s0_readdata[0]);
      end
   end

   // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
   function automatic logic [DW-1:0] lfsr_word();
      logic [DW-1:0] w;
      logic          fb;
      w = '0;
      for (int i = 0; i < DW; i++)
      begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         w = {w[DW-2:0], fb};
      end
      return w;
   endfunction

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // Drives one command at the current rising edge
   task automatic drive_cmd(input int b, input logic wr, input logic [AW-1:0] addr,
                            input logic [DW-1:0] data, input logic [BW-1:0] burst,
                            input logic [BEW-1:0] be);
      s0_write[b]      <= wr;
      s0_read[b]       <= ~wr;
      s0_address[b]    <= addr;
      s0_writedata[b]  <= data;
      s0_burstcount[b] <= burst;
      s0_byteenable[b] <= be;
   endtask

   // Returns at the rising edge that accepts the driven command
   task automatic wait_accept(input int b);
      int t;
      t = 0;
      @(negedge Clk_100);
      while (s0_waitrequest[b] && t < TO)
      begin
         @(negedge Clk_100);
         t++;
      end
      if (t >= TO)
      begin
         $display("Timeout: bank %0d never accepted a command", b);
         timeouts++;
      end
      @(posedge Clk_100);
   endtask

   task automatic issue(input int b, input logic wr, input logic [AW-1:0] addr,
                        input logic [DW-1:0] data);
      drive_cmd(b, wr, addr, data, BW'(1), '1);
      wait_accept(b);
   endtask

   task automatic release_cmd(input int b);
      s0_write[b] <= 1'b0;
      s0_read[b]  <= 1'b0;
   endtask

   task automatic wait_queue(input int n, input int which);
      int t;
      t = 0;
      while (((which == 0) ? wr_data_q.size() : rd_data_q.size()) < n && t < TO)
      begin
         @(negedge Clk_100);
         t++;
      end
      if (t >= TO)
      begin
         $display("Timeout: expected %0d transfers, not all arrived", n);
         timeouts++;
      end
   endtask

   // ========================================
   // Directed tests
   // ========================================

   task automatic reset_release();
      int n;
      repeat (4) @(posedge Clk_100);
      @(negedge Clk_100);
      check("bank_reset", 64'(bank_reset), 64'(2'b11));
      check("s0_readdatavalid", 64'(s0_readdatavalid), 64'(0));
      @(posedge Clk_100);
      rst_n <= 1'b1;
      n = 0;
      do
      begin
         @(posedge Clk_100);
         n++;
         @(negedge Clk_100);
      end
      while (bank_reset[0] && n < TO);
      check("reset latency", 64'(n), 64'(reset_cfg_pkg::RESET_LATENCY));
      check("bank_reset", 64'(bank_reset), 64'(0));
   endtask

   task automatic command_pass_through();
      logic [DW-1:0] d;
      d = lfsr_word();
      @(posedge Clk_100);
      drive_cmd(0, 1'b1, AW'(16'h0003), d, BW'(3), BEW'(8'h0F));
      wait_accept(0);
      release_cmd(0);
      @(negedge Clk_100);
      check("m0_write", 64'(m0_write[0]), 64'(1));
      check("m0_read", 64'(m0_read[0]), 64'(0));
      check("m0_address", 64'(m0_address[0]), 64'(16'h0003));
      check("m0_writedata", 64'(m0_writedata[0]), 64'(d));
      check("m0_burstcount", 64'(m0_burstcount[0]), 64'(3));
      check("m0_byteenable", 64'(m0_byteenable[0]), 64'(8'h0F));
   endtask

   task automatic write_then_read();
      logic [DW-1:0] d;
      int            t;
      int            n;
      for (int b = 0; b < NB; b++)
      begin
         d = lfsr_word();
         @(posedge Clk_100);
         issue(b, 1'b1, AW'(9), d);
         issue(b, 1'b0, AW'(9), '0);
         release_cmd(b);
         t = 0;
         @(negedge Clk_100);
         while (!(m0_read[b] && !m0_waitrequest[b]) && t < TO)
         begin
            @(negedge Clk_100);
            t++;
         end
         if (t >= TO)
         begin
            $display("Timeout: bank %0d never presented the read to memory", b);
            timeouts++;
         end
         n = 0;
         do
         begin
            @(posedge Clk_100);
            n++;
            @(negedge Clk_100);
         end
         while (!s0_readdatavalid[b] && n < TO);
         check("s0_readdata", 64'(s0_readdata[b]), 64'(d));
         check("read latency", 64'(n), 64'(DEPTH + 1));
      end
   endtask

   task automatic back_pressure();
      logic [DW-1:0] da;
      logic [DW-1:0] db;
      da = lfsr_word();
      db = lfsr_word();
      wr_addr_q.delete();
      wr_data_q.delete();
      @(posedge Clk_100);
      m0_waitrequest[0] <= 1'b1;
      issue(0, 1'b1, AW'(5), da);
      // Second command meets a full command register
      drive_cmd(0, 1'b1, AW'(6), db, BW'(1), '1);
      @(negedge Clk_100);
      check("s0_waitrequest", 64'(s0_waitrequest[0]), 64'(1));
      repeat (3) @(posedge Clk_100);
      m0_waitrequest[0] <= 1'b0;
      wait_accept(0);
      release_cmd(0);
      wait_queue(2, 0);
      if (wr_data_q.size() == 2)
      begin
         check("first m0_address", 64'(wr_addr_q[0]), 64'(5));
         check("first m0_writedata", 64'(wr_data_q[0]), 64'(da));
         check("second m0_address", 64'(wr_addr_q[1]), 64'(6));
         check("second m0_writedata", 64'(wr_data_q[1]), 64'(db));
      end
   endtask

   task automatic pipelined_reads();
      logic [DW-1:0] exp [4];
      for (int i = 0; i < 4; i++)
      begin
         exp[i] = lfsr_word();
         @(posedge Clk_100);
         issue(0, 1'b1, AW'(10 + i), exp[i]);
         release_cmd(0);
         issue(1, 1'b1, AW'(10 + i), lfsr_word());
         release_cmd(1);
      end
      rd_data_q.delete();
      @(posedge Clk_100);
      for (int i = 0; i < 4; i++)
      begin
         issue(0, 1'b0, AW'(10 + i), '0);
      end
      release_cmd(0);
      wait_queue(4, 1);
      for (int i = 0; i < 4 && i < rd_data_q.size(); i++)
      begin
         check("s0_readdata", 64'(rd_data_q[i]), 64'(exp[i]));
      end
   endtask

   initial
   begin
      reset_release();
      command_pass_through();
      write_then_read();
      back_pressure();
      pipelined_reads();
      repeat (4) @(posedge Clk_100);
      $display("Check errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Watchdog for the whole run
   initial
   begin
      #200000;
      $display("Run exceeded its time limit");
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- compile.f
common/mem_cfg_pkg.sv
common/reset_cfg_pkg.sv
hdl/reset_resync.sv
local_mem/avmm_pipe_bridge.sv
local_mem/local_mem_bank.sv
hdl/green_shell_top.sv
testbench/tb_green_shell.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the local memory shell testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_green_shell \
   -f compile.f \
   -o sim_green_shell > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see build.log"
   exit 1
fi

./obj_dir/sim_green_shell > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" sim.log; then
   exit 1
fi

exit 0
